/* hw/float_pkg.sv */
/*
 * binary32 field and width types, format constants,
 * flag and result structs for the multiply unit
 */
`default_nettype none

package float_pkg;

  // ==========================================================
  // field types
  // ==========================================================

  // one binary32 word as it travels between blocks
  typedef logic [31:0] float32_t;

  // biased exponent field
  typedef logic [7:0] exponent_t;

  // stored fraction, hidden bit not included
  typedef logic [22:0] mantissa_t;

  // fraction with hidden bit prepended, 1.23 format
  typedef logic [23:0] significand_t;

  // truncated significand product, 2.23 format
  typedef logic [24:0] sig_product_t;

  // widened signed exponent, wide enough for e_a + e_b - bias + 1
  typedef logic signed [9:0] exp_wide_t;

  // ==========================================================
  // format constants
  // ==========================================================

  localparam exponent_t exp_bias = 8'd127;
  // all-ones exponent marks infinity and NaN
  localparam exponent_t exp_max = 8'd255;
  // negative quiet NaN, fraction msb set
  localparam float32_t canonical_nan = {1'b1, exp_max, 23'h40_0000};

  // significand multiplier geometry
  localparam int unsigned sig_width = 24;
  localparam int unsigned frac_bits = 23;

  // ==========================================================
  // status and result
  // ==========================================================

  typedef struct packed {
    logic invalid;
    logic overflow;
    logic underflow;
  } fmul_flags_t;

  // product word plus its flags, 35 bits
  typedef struct packed {
    float32_t    product;
    fmul_flags_t flags;
  } fmul_result_t;

endpackage

`default_nettype wire

/* hw/fmul_ctrl_pkg.sv */
/*
 * handshake operand bundle and controller state encoding
 */
`default_nettype none

package fmul_ctrl_pkg;

  // both operands captured together on request
  typedef struct packed {
    float_pkg::float32_t a;
    float_pkg::float32_t b;
  } fmul_operands_t;

  // four-phase controller states
  //   st_idle     waiting for req
  //   st_compute  operands held, multiplier settling
  //   st_respond  ack high until req drops
  //   st_release  one cycle gap before the next request
  typedef enum logic [1:0] {
    st_idle    = 2'd0,
    st_compute = 2'd1,
    st_respond = 2'd2,
    st_release = 2'd3
  } ctrl_state_e;

endpackage

`default_nettype wire

/* hw/fixed_point_multiplier.sv */
/*
 * unsigned fixed-point multiplier, product truncated to the
 * operand fraction width with one extra integer bit
 */
`default_nettype none

module fixed_point_multiplier #(
  // total operand width, integer plus fraction bits
  parameter int unsigned width     = 16,
  // fraction bits in each operand
  parameter int unsigned frac_bits = 8
) (
  input  logic [width-1:0] a,
  input  logic [width-1:0] b,
  output logic [width:0]   product
);

  // ==========================================================
  // full-precision product
  // ==========================================================

  // product of two i.f numbers carries 2f fraction bits
  logic [2*width-1:0] full_product;

  always_comb begin
    full_product = a * b;
  end

  // ==========================================================
  // truncation
  // ==========================================================

  // drop the low frac_bits fraction bits so the result is back
  // in the operand's fraction format
  // one extra top bit keeps the carry into the next integer position
  // for 1.23 operands this yields a 2.23 product
  assign product = full_product[frac_bits +: width+1];

endmodule

`default_nettype wire

/* hw/float_special_cases.sv */
/*
 * binary32 operand classification and special-case override
 * for NaN, infinity and zero operands
 */
`default_nettype none

module float_special_cases (
  input  float_pkg::float32_t a,
  input  float_pkg::float32_t b,
  output logic                use_special,
  output float_pkg::float32_t special_value,
  output logic                invalid
);

  import float_pkg::*;

  // field split
  exponent_t exp_a;
  exponent_t exp_b;
  mantissa_t man_a;
  mantissa_t man_b;

  // classification flags
  logic a_nan;
  logic b_nan;
  logic a_inf;
  logic b_inf;
  logic a_zero;
  logic b_zero;

  // sign of any infinite or zero result
  logic sign_xor;

  assign exp_a = a[30:23];
  assign man_a = a[22:0];
  assign exp_b = b[30:23];
  assign man_b = b[22:0];

  // ==========================================================
  // classify
  // ==========================================================

  // each operand checks its own fraction
  assign a_nan  = (exp_a == exp_max) && (man_a != '0);
  assign b_nan  = (exp_b == exp_max) && (man_b != '0);
  assign a_inf  = (exp_a == exp_max) && (man_a == '0);
  assign b_inf  = (exp_b == exp_max) && (man_b == '0);
  // subnormals flush, so any zero exponent field counts as zero
  assign a_zero = (exp_a == '0);
  assign b_zero = (exp_b == '0);

  assign sign_xor = a[31] ^ b[31];

  // ==========================================================
  // priority select
  // ==========================================================

  always_comb begin
    use_special   = 1'b0;
    special_value = '0;
    invalid       = 1'b0;
    if (a_nan) begin
      // NaN on a wins and passes through untouched
      use_special   = 1'b1;
      special_value = a;
    end else if (b_nan) begin
      use_special   = 1'b1;
      special_value = b;
    end else if ((a_inf && b_zero) || (b_inf && a_zero)) begin
      // inf * 0 has no defined value
      use_special   = 1'b1;
      special_value = canonical_nan;
      invalid       = 1'b1;
    end else if (a_inf || b_inf) begin
      use_special   = 1'b1;
      special_value = {sign_xor, exp_max, mantissa_t'(0)};
    end else if (a_zero || b_zero) begin
      // signed zero, the other side is known finite here
      use_special   = 1'b1;
      special_value = {sign_xor, exponent_t'(0), mantissa_t'(0)};
    end
  end

endmodule

`default_nettype wire

/* hw/float_multiplier.sv */
/*
 * combinational binary32 multiply with truncating normalization,
 * exponent saturation or flush and special-case selection
 */
`default_nettype none

module float_multiplier (
  input  fmul_ctrl_pkg::fmul_operands_t operands,
  output float_pkg::fmul_result_t       result
);

  import float_pkg::*;

  // operand fields
  logic         sign_a;
  logic         sign_b;
  exponent_t    exp_a;
  exponent_t    exp_b;
  significand_t sig_a;
  significand_t sig_b;

  // normal path
  logic         sign_out;
  sig_product_t sig_prod;
  logic         norm_carry;
  mantissa_t    man_norm;
  exp_wide_t    exp_sum;
  logic         exp_over;
  logic         exp_under;
  float32_t     normal_value;

  // special-case override
  logic         use_special;
  float32_t     special_value;
  logic         invalid;

  assign sign_a = operands.a[31];
  assign sign_b = operands.b[31];
  assign exp_a  = operands.a[30:23];
  assign exp_b  = operands.b[30:23];

  // hidden bit in front of the stored fraction
  assign sig_a = {1'b1, operands.a[22:0]};
  assign sig_b = {1'b1, operands.b[22:0]};

  // ==========================================================
  // significand product
  // ==========================================================

  fixed_point_multiplier #(
    .width    (sig_width),
    .frac_bits(frac_bits)
  ) sig_mul_i (
    .a      (sig_a),
    .b      (sig_b),
    .product(sig_prod)
  );

  // ==========================================================
  // normalize and exponent
  // ==========================================================

  // product lies in [1, 4), top bit set means shift right by one
  assign norm_carry = sig_prod[24];
  // the leading one becomes the hidden bit and is dropped
  assign man_norm   = norm_carry ? sig_prod[23:1] : sig_prod[22:0];

  // 10-bit signed sum so the range checks see the real value
  assign exp_sum = exp_wide_t'(exp_a) + exp_wide_t'(exp_b)
                 - exp_wide_t'(exp_bias) + exp_wide_t'(norm_carry);

  assign exp_over  = (exp_sum >= exp_wide_t'(exp_max));
  assign exp_under = (exp_sum <= exp_wide_t'(0));

  assign sign_out = sign_a ^ sign_b;

  always_comb begin
    if (exp_over) begin
      // saturate to signed infinity
      normal_value = {sign_out, exp_max, mantissa_t'(0)};
    end else if (exp_under) begin
      // flush to signed zero
      normal_value = {sign_out, exponent_t'(0), mantissa_t'(0)};
    end else begin
      normal_value = {sign_out, exp_sum[7:0], man_norm};
    end
  end

  // ==========================================================
  // special cases and output select
  // ==========================================================

  float_special_cases special_i (
    .a            (operands.a),
    .b            (operands.b),
    .use_special  (use_special),
    .special_value(special_value),
    .invalid      (invalid)
  );

  always_comb begin
    if (use_special) begin
      result.product         = special_value;
      result.flags.invalid   = invalid;
      result.flags.overflow  = 1'b0;
      result.flags.underflow = 1'b0;
    end else begin
      result.product         = normal_value;
      result.flags.invalid   = 1'b0;
      result.flags.overflow  = exp_over;
      result.flags.underflow = exp_under;
    end
  end

endmodule

`default_nettype wire

/* hw/fmul_handshake_ctrl.sv */
/*
 * four-phase req/ack controller with operand capture
 * and result hold registers
 */
`default_nettype none

module fmul_handshake_ctrl (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          req,
  input  fmul_ctrl_pkg::fmul_operands_t operands,
  output logic                          ack,
  output float_pkg::fmul_result_t       result,
  output fmul_ctrl_pkg::fmul_operands_t mul_operands,
  input  float_pkg::fmul_result_t       mul_result
);

  import float_pkg::*;
  import fmul_ctrl_pkg::*;

  ctrl_state_e    state_q;
  ctrl_state_e    state_d;
  logic           ack_q;
  fmul_operands_t op_q;
  fmul_result_t   result_q;

  // events on the current edge
  logic capture;
  logic finish;
  logic drop;

  assign capture = (state_q == st_idle) && req;
  assign finish  = (state_q == st_compute);
  assign drop    = (state_q == st_respond) && !req;

  // ==========================================================
  // state machine
  // ==========================================================

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      st_idle: begin
        if (req) begin
          state_d = st_compute;
        end
      end
      // single settle cycle for the multiplier
      st_compute: state_d = st_respond;
      st_respond: begin
        // requester holds req as long as it wants the result
        if (!req) begin
          state_d = st_release;
        end
      end
      st_release: state_d = st_idle;
      default:    state_d = st_idle;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q  <= st_idle;
      ack_q    <= 1'b0;
      result_q <= '0;
    end else begin
      state_q <= state_d;
      if (finish) begin
        // result and ack appear together
        result_q <= mul_result;
        ack_q    <= 1'b1;
      end else if (drop) begin
        ack_q <= 1'b0;
      end
    end
  end

  // ==========================================================
  // operand capture
  // ==========================================================

  // requester may change operands once req has been taken
  always_ff @(posedge clk) begin
    if (capture) begin
      op_q <= operands;
    end
  end

  assign mul_operands = op_q;
  assign ack          = ack_q;
  // held past the ack fall until the next compute
  assign result       = result_q;

endmodule

`default_nettype wire

/* hw/fmul_top.sv */
/*
 * float multiply unit top, handshake controller around
 * the combinational binary32 multiplier
 */
`default_nettype none

module fmul_top (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          req,
  input  fmul_ctrl_pkg::fmul_operands_t operands,
  output logic                          ack,
  output float_pkg::fmul_result_t       result
);

  import float_pkg::*;
  import fmul_ctrl_pkg::*;

  // registered operands into the datapath
  fmul_operands_t mul_operands;
  // datapath output, registered by the controller
  fmul_result_t   mul_result;

  fmul_handshake_ctrl ctrl_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .req         (req),
    .operands    (operands),
    .ack         (ack),
    .result      (result),
    .mul_operands(mul_operands),
    .mul_result  (mul_result)
  );

  // zero-latency datapath
  float_multiplier fmul_i (
    .operands(mul_operands),
    .result  (mul_result)
  );

endmodule

`default_nettype wire

/* bench/fmul_tb.sv */
/*
 * binary32 multiply unit testbench with directed and random stimulus,
 * reference model, typed compare tasks and a watchdog
 */
`default_nettype none

module fmul_tb;

  timeunit 1ns;
  timeprecision 1ps;

  import float_pkg::*;
  import fmul_ctrl_pkg::*;

  // transactions per test group
  localparam int n_normal    = 500;
  localparam int n_nan       = 40;
  localparam int n_infinity  = 40;
  localparam int n_range     = 100;
  localparam int n_zero      = 40;
  localparam int n_handshake = 20;
  localparam int total_txn   = n_normal + n_nan + n_infinity + n_range + n_zero + n_handshake;

  logic           clk;
  logic           rst_n;
  logic           req;
  fmul_operands_t operands;
  logic           ack;
  fmul_result_t   result;

  int    seed = 32'ha368_f0a0;
  string test_name;
  int    test_errors;
  int    test_txns;
  int    tests_ok;
  int    tests_failing;

  fmul_top dut_i (
    .clk     (clk),
    .rst_n   (rst_n),
    .req     (req),
    .operands(operands),
    .ack     (ack),
    .result  (result)
  );

  initial clk = 1'b0;
  always #5 clk = ~clk;

  // ==========================================================
  // random helpers and reference model
  // ==========================================================

  function automatic int rand_range(input int lo, input int hi);
    return lo + int'($unsigned($random(seed)) % (hi - lo + 1));
  endfunction

  // never zero so that exponent 255 with this fraction is a NaN
  function automatic mantissa_t rand_mantissa_nz();
    mantissa_t m;
    m = mantissa_t'($random(seed));
    if (m == '0) m = mantissa_t'(1);
    return m;
  endfunction

  function automatic float32_t make_float(input logic s, input int e, input mantissa_t m);
    return {s, exponent_t'(e), m};
  endfunction

  // IEEE product without rounding or subnormals and with NaNs passed untouched
  function automatic fmul_result_t model_multiply(input float32_t a, input float32_t b);
    fmul_result_t r;
    logic [47:0]  prod;
    mantissa_t    man;
    int           exp_val;
    logic         sign;
    logic         a_nan;
    logic         b_nan;
    logic         a_inf;
    logic         b_inf;
    logic         a_zero;
    logic         b_zero;
    r      = '0;
    sign   = a[31] ^ b[31];
    a_nan  = (a[30:23] == 8'hff) && (a[22:0] != 0);
    b_nan  = (b[30:23] == 8'hff) && (b[22:0] != 0);
    a_inf  = (a[30:23] == 8'hff) && (a[22:0] == 0);
    b_inf  = (b[30:23] == 8'hff) && (b[22:0] == 0);
    a_zero = (a[30:23] == 8'h00);
    b_zero = (b[30:23] == 8'h00);
    if (a_nan) begin
      r.product = a;
    end else if (b_nan) begin
      r.product = b;
    end else if ((a_inf && b_zero) || (b_inf && a_zero)) begin
      r.product       = canonical_nan;
      r.flags.invalid = 1'b1;
    end else if (a_inf || b_inf) begin
      r.product = {sign, 8'hff, 23'h0};
    end else if (a_zero || b_zero) begin
      r.product = {sign, 31'h0};
    end else begin
      // 1.23 times 1.23 gives 2.46 and 23 fraction bits below the leading one are kept
      prod    = {1'b1, a[22:0]} * {1'b1, b[22:0]};
      exp_val = int'(a[30:23]) + int'(b[30:23]) - int'(exp_bias);
      if (prod[47]) begin
        exp_val = exp_val + 1;
        man     = prod[46:24];
      end else begin
        man = prod[45:23];
      end
      if (exp_val >= 255) begin
        r.product        = {sign, 8'hff, 23'h0};
        r.flags.overflow = 1'b1;
      end else if (exp_val <= 0) begin
        r.product         = {sign, 31'h0};
        r.flags.underflow = 1'b1;
      end else begin
        r.product = {sign, exponent_t'(exp_val), man};
      end
    end
    return r;
  endfunction

  // ==========================================================
  // compare tasks
  // ==========================================================

  task automatic check_product(input string name, input float32_t exp_v, input float32_t act_v);
    if (exp_v !== act_v) begin
      $display("error: %s product expected %h actual %h", name, exp_v, act_v);
      test_errors++;
    end
  endtask

  task automatic check_flags(input string name, input fmul_flags_t exp_v,
                             input fmul_flags_t act_v);
    if (exp_v !== act_v) begin
      $display("error: %s flags (inv ovf unf) expected %b actual %b", name, exp_v, act_v);
      test_errors++;
    end
  endtask

  task automatic check_handshake(input string name, input logic exp_v, input logic act_v);
    if (exp_v !== act_v) begin
      $display("error: %s ack expected %b actual %b", name, exp_v, act_v);
      test_errors++;
    end
  endtask

  // ==========================================================
  // one four-phase transaction
  // ==========================================================

  // outputs sampled on falling edges and inputs driven on rising edges
  task automatic run_transaction(input float32_t a, input float32_t b, input int hold);
    fmul_result_t expected;
    fmul_result_t seen;
    int           waited;
    expected = model_multiply(a, b);
    test_txns++;
    @(posedge clk);
    req        <= 1'b1;
    operands.a <= a;
    operands.b <= b;
    // req not sampled yet
    @(negedge clk);
    check_handshake({test_name, " ack idle"}, 1'b0, ack);
    // first edge samples req and captures the operands
    @(negedge clk);
    check_handshake({test_name, " ack early"}, 1'b0, ack);
    // second edge registers the result and raises ack
    @(negedge clk);
    check_handshake({test_name, " ack latency"}, 1'b1, ack);
    waited = 3;
    while (!ack && waited < 16) begin
      @(negedge clk);
      waited++;
    end
    if (!ack) begin
      $display("%s: ack never rose after the request", test_name);
      test_errors++;
      @(posedge clk);
      req <= 1'b0;
      return;
    end
    seen = result;
    check_product(test_name, expected.product, seen.product);
    check_flags(test_name, expected.flags, seen.flags);
    // requester keeps req high and everything must hold
    repeat (hold) begin
      @(negedge clk);
      check_handshake({test_name, " ack hold"}, 1'b1, ack);
      check_product({test_name, " hold"}, seen.product, result.product);
      check_flags({test_name, " hold"}, seen.flags, result.flags);
    end
    @(posedge clk);
    req      <= 1'b0;
    // operands are free to change once req is low
    operands <= {$random(seed), $random(seed)};
    // this edge still saw req high
    @(negedge clk);
    check_handshake({test_name, " ack before release"}, 1'b1, ack);
    // first edge with req low clears ack
    @(negedge clk);
    check_handshake({test_name, " ack release"}, 1'b0, ack);
    check_product({test_name, " after release"}, seen.product, result.product);
    check_flags({test_name, " after release"}, seen.flags, result.flags);
  endtask

  task automatic start_test(input string name);
    test_name   = name;
    test_errors = 0;
    test_txns   = 0;
  endtask

  task automatic end_test();
    if (test_errors == 0) begin
      tests_ok++;
      $display("test %s: ok (%0d transactions)", test_name, test_txns);
    end else begin
      tests_failing++;
      $display("test %s: FAILED with %0d errors (%0d transactions)",
               test_name, test_errors, test_txns);
    end
  endtask

  // ==========================================================
  // test groups
  // ==========================================================

  // exponents 64..190 keep the biased result inside 1..254
  task automatic normal_products();
    repeat (n_normal) begin
      run_transaction(make_float($random(seed), rand_range(64, 190), $random(seed)),
                      make_float($random(seed), rand_range(64, 190), $random(seed)), 0);
    end
  endtask

  task automatic nan_propagation();
    float32_t nan_a;
    float32_t other;
    repeat (n_nan / 2) begin
      // a NaN wins over any b including a NaN
      nan_a = make_float($random(seed), 255, rand_mantissa_nz());
      other = ($random(seed) & 1) ? make_float($random(seed), 255, rand_mantissa_nz())
                                  : float32_t'($random(seed));
      run_transaction(nan_a, other, 0);
      // b NaN with a any non-NaN word
      other = make_float($random(seed), rand_range(0, 254), $random(seed));
      run_transaction(other, make_float($random(seed), 255, rand_mantissa_nz()), 0);
    end
  endtask

  task automatic infinity_cases();
    float32_t inf_v;
    float32_t zero_v;
    float32_t norm_v;
    repeat (n_infinity / 5) begin
      inf_v  = make_float($random(seed), 255, '0);
      zero_v = make_float($random(seed), 0, $random(seed));
      norm_v = make_float($random(seed), rand_range(1, 254), $random(seed));
      run_transaction(inf_v, zero_v, 0);
      run_transaction(zero_v, inf_v, 0);
      run_transaction(inf_v, norm_v, 0);
      run_transaction(norm_v, inf_v, 0);
      run_transaction(inf_v, make_float($random(seed), 255, '0), 0);
    end
  endtask

  // exponent pairs straddling the 255 and 0 limits of the biased sum
  task automatic range_limits();
    int e_a;
    int e_b;
    for (int i = 0; i < n_range; i++) begin
      if (i % 2 == 0) begin
        e_a = rand_range(127, 254);
        e_b = 381 - e_a + rand_range(-3, 3);
      end else begin
        e_a = rand_range(1, 126);
        e_b = 127 - e_a + rand_range(-3, 3);
      end
      if (e_b < 1) e_b = 1;
      if (e_b > 254) e_b = 254;
      run_transaction(make_float($random(seed), e_a, $random(seed)),
                      make_float($random(seed), e_b, $random(seed)), 0);
    end
  endtask

  // exponent field 0 flushes whatever the fraction holds
  task automatic zero_operands();
    float32_t zero_v;
    float32_t norm_v;
    repeat (n_zero / 2) begin
      zero_v = make_float($random(seed), 0, $random(seed));
      norm_v = make_float($random(seed), rand_range(1, 254), $random(seed));
      run_transaction(zero_v, norm_v, 0);
      run_transaction(norm_v, zero_v, 0);
    end
  endtask

  task automatic handshake_timing();
    repeat (n_handshake) begin
      run_transaction(make_float($random(seed), rand_range(64, 190), $random(seed)),
                      make_float($random(seed), rand_range(64, 190), $random(seed)),
                      rand_range(0, 8));
    end
  endtask

  // ==========================================================
  // main sequence and watchdog
  // ==========================================================

  initial begin
    rst_n         = 1'b0;
    req           = 1'b0;
    operands      = '0;
    tests_ok      = 0;
    tests_failing = 0;
    repeat (3) @(posedge clk);
    rst_n <= 1'b1;
    start_test("reset_state");
    @(negedge clk);
    check_handshake(test_name, 1'b0, ack);
    check_product(test_name, '0, result.product);
    check_flags(test_name, '0, result.flags);
    end_test();
    start_test("random_normal");
    normal_products();
    end_test();
    start_test("nan_propagation");
    nan_propagation();
    end_test();
    start_test("infinity");
    infinity_cases();
    end_test();
    start_test("exponent_range");
    range_limits();
    end_test();
    start_test("zero_subnormal");
    zero_operands();
    end_test();
    start_test("handshake");
    handshake_timing();
    end_test();
    $display("tests: %0d ok, %0d failing", tests_ok, tests_failing);
    if (tests_failing == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

  // budget of 10 cycles per transaction plus 1 us slack
  initial begin
    #(real'(total_txn) * 100.0 + 1000.0);
    $display("watchdog timeout: the tests did not finish in the expected time");
    $display("Some tests failed");
    $finish;
  end

endmodule

`default_nettype wire

/* fmul_unit.f */
hw/float_pkg.sv
hw/fmul_ctrl_pkg.sv
hw/fixed_point_multiplier.sv
hw/float_special_cases.sv
hw/float_multiplier.sv
hw/fmul_handshake_ctrl.sv
hw/fmul_top.sv
bench/fmul_tb.sv

/* Bender.yml */
package:
  name: fmul_unit

sources:
  # packages first, then leaf modules up to the top level
  - hw/float_pkg.sv
  - hw/fmul_ctrl_pkg.sv
  - hw/fixed_point_multiplier.sv
  - hw/float_special_cases.sv
  - hw/float_multiplier.sv
  - hw/fmul_handshake_ctrl.sv
  - hw/fmul_top.sv
  - target: test
    files:
      - bench/fmul_tb.sv
